//--- Bender.yml
package:
  name: cache

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - setStore.sv
      - lruAges.sv
      - tagMatch.sv
      - cacheController.sv
      - cacheTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - cache_sva.sv
      - tb_cache.sv

//--- cacheController.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cacheController import cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`CACHE_ADDR_BITS-1:0] sAwaddr,
	input logic sAwvalid,
	output logic sAwready,
	input word_t sWdata,
	input logic [`CACHE_WORD_BITS/8-1:0] sWstrb,
	input logic sWvalid,
	output logic sWready,
	output logic [1:0] sBresp,
	output logic sBvalid,
	input logic sBready,
	input logic [`CACHE_ADDR_BITS-1:0] sAraddr,
	input logic sArvalid,
	output logic sArready,
	output word_t sRdata,
	output logic [1:0] sRresp,
	output logic sRvalid,
	input logic sRready,
	output logic [`CACHE_ADDR_BITS-1:0] mAwaddr,
	output logic mAwvalid,
	input logic mAwready,
	output word_t mWdata,
	output logic [`CACHE_WORD_BITS/8-1:0] mWstrb,
	output logic mWvalid,
	input logic mWready,
	input logic mBvalid,
	output logic mBready,
	output logic [`CACHE_ADDR_BITS-1:0] mAraddr,
	output logic mArvalid,
	input logic mArready,
	input word_t mRdata,
	input logic mRvalid,
	output logic mRready,
	output setIdx_t setIdx,
	output wayMask_t tagWrMask,
	output tagEntry_t tagWrData,
	output wayMask_t lineWrMask,
	output line_t lineWrData,
	input line_t lineWays [`CACHE_WAYS],
	input logic hit,
	input way_t hitWay,
	input way_t victimWay,
	output tag_t reqTag,
	output logic touch,
	output way_t touchWay
);
	typedef enum logic [2:0]
	{
		stIdle,
		stLookup,
		stRefillAddr,
		stRefillData,
		stRespond,
		stWriteMem,
		stWriteResp
	} state_t;

	state_t state;
	state_t stateNext;
	logic idleReady; // high only while idle and out of reset
	logic [`CACHE_ADDR_BITS-1:0] addrQ;
	word_t wdataQ;
	logic [`CACHE_WORD_BITS/8-1:0] wstrbQ;
	word_t rdataQ;
	line_t lineBuf;
	line_t fillLine;
	line_t hitLine;
	wordSel_t wordSel;
	wordSel_t wordCnt;
	logic awDone;
	logic wDone;
	logic arAccept;
	logic wrAccept;
	logic rdHit;
	logic fillDone;
	logic wrDone;
	logic wrHit;

	assign reqTag = addrQ[`CACHE_ADDR_BITS-1:`CACHE_TAG_LSB];
	assign setIdx = addrQ[`CACHE_TAG_LSB-1:`CACHE_SET_LSB];
	assign wordSel = addrQ[`CACHE_SET_LSB-1:`CACHE_WORD_LSB];

	// reads win, aw and w only transfer together
	assign sArready = idleReady;
	assign sAwready = idleReady && !sArvalid && sWvalid;
	assign sWready = idleReady && !sArvalid && sAwvalid;
	assign arAccept = sArvalid && sArready;
	assign wrAccept = sAwvalid && sAwready;

	assign sRvalid = (state == stRespond);
	assign sRdata = rdataQ;
	assign sRresp = 2'b00; // always okay
	assign sBvalid = (state == stWriteResp);
	assign sBresp = 2'b00;

	assign mArvalid = (state == stRefillAddr);
	assign mAraddr = {reqTag, setIdx, wordCnt, {`CACHE_WORD_LSB{1'b0}}};
	assign mRready = (state == stRefillData);
	assign mAwvalid = (state == stWriteMem) && !awDone;
	assign mAwaddr = addrQ;
	assign mWvalid = (state == stWriteMem) && !wDone;
	assign mWdata = wdataQ;
	assign mWstrb = wstrbQ;
	assign mBready = (state == stWriteMem) && awDone && wDone;

	assign rdHit = (state == stLookup) && hit;
	assign fillDone = mRvalid && mRready && (wordCnt == wordSel_t'(`CACHE_LINE_WORDS-1));
	assign wrDone = mBvalid && mBready;
	assign wrHit = wrDone && hit; // write misses do not allocate

	assign touch = rdHit || fillDone || wrHit;
	assign touchWay = fillDone ? victimWay : hitWay;
	assign tagWrMask = fillDone ? (wayMask_t'(1) << victimWay) : '0;
	assign tagWrData = '{valid: 1'b1, tag: reqTag};
	assign lineWrMask = fillDone ? (wayMask_t'(1) << victimWay) :
		wrHit ? (wayMask_t'(1) << hitWay) : '0;

	always_comb
	begin
		fillLine = lineBuf;
		fillLine[wordCnt] = mRdata; // last beat goes straight in
		hitLine = lineWays[hitWay];
		hitLine[wordSel] = wdataQ;
		lineWrData = fillDone ? fillLine : hitLine;
	end

	always_comb
	begin
		stateNext = state;
		case (state)
			stIdle:
				if (arAccept)
					stateNext = stLookup;
				else if (wrAccept)
					stateNext = stWriteMem;
			stLookup:
				stateNext = hit ? stRespond : stRefillAddr;
			stRefillAddr:
				if (mArready)
					stateNext = stRefillData;
			stRefillData:
				if (fillDone)
					stateNext = stRespond;
				else if (mRvalid)
					stateNext = stRefillAddr; // next word of the line
			stRespond:
				if (sRready)
					stateNext = stIdle;
			stWriteMem:
				if (wrDone)
					stateNext = stWriteResp;
			stWriteResp:
				if (sBready)
					stateNext = stIdle;
			default:
				stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stIdle;
			idleReady <= 1'b0;
			wordCnt <= '0;
			awDone <= 1'b0;
			wDone <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			idleReady <= (stateNext == stIdle);
			if (state == stLookup)
				wordCnt <= '0;
			else if (mRvalid && mRready)
				wordCnt <= wordCnt + 1'b1;
			if (wrAccept)
			begin
				awDone <= 1'b0;
				wDone <= 1'b0;
			end
			else
			begin
				if (mAwvalid && mAwready)
					awDone <= 1'b1;
				if (mWvalid && mWready)
					wDone <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (arAccept)
			addrQ <= sAraddr;
		else if (wrAccept)
		begin
			addrQ <= sAwaddr;
			wdataQ <= sWdata;
			wstrbQ <= sWstrb;
		end
		if (mRvalid && mRready)
			lineBuf[wordCnt] <= mRdata;
		if (rdHit)
			rdataQ <= lineWays[hitWay][wordSel];
		else if (fillDone)
			rdataQ <= fillLine[wordSel];
	end

endmodule

//--- cacheTop.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cacheTop import cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`CACHE_ADDR_BITS-1:0] sAwaddr,
	input logic sAwvalid,
	output logic sAwready,
	input word_t sWdata,
	input logic [`CACHE_WORD_BITS/8-1:0] sWstrb,
	input logic sWvalid,
	output logic sWready,
	output logic [1:0] sBresp,
	output logic sBvalid,
	input logic sBready,
	input logic [`CACHE_ADDR_BITS-1:0] sAraddr,
	input logic sArvalid,
	output logic sArready,
	output word_t sRdata,
	output logic [1:0] sRresp,
	output logic sRvalid,
	input logic sRready,
	output logic [`CACHE_ADDR_BITS-1:0] mAwaddr,
	output logic mAwvalid,
	input logic mAwready,
	output word_t mWdata,
	output logic [`CACHE_WORD_BITS/8-1:0] mWstrb,
	output logic mWvalid,
	input logic mWready,
	input logic mBvalid,
	output logic mBready,
	output logic [`CACHE_ADDR_BITS-1:0] mAraddr,
	output logic mArvalid,
	input logic mArready,
	input word_t mRdata,
	input logic mRvalid,
	output logic mRready
);
	setIdx_t setIdx;
	wayMask_t tagWrMask;
	tagEntry_t tagWrData;
	wayMask_t lineWrMask;
	line_t lineWrData;
	tagEntry_t tagWays [`CACHE_WAYS];
	line_t lineWays [`CACHE_WAYS];
	logic hit;
	way_t hitWay;
	way_t victimWay;
	tag_t reqTag;
	logic touch;
	way_t touchWay;

	cacheController cacheController_i (.*);

	setStore #(.payload_t(tagEntry_t)) tagStore
	(
		.clk,
		.reset,
		.setIdx,
		.wrMask(tagWrMask),
		.wrData(tagWrData),
		.rdWays(tagWays)
	);

	setStore #(.payload_t(line_t)) dataStore
	(
		.clk,
		.reset,
		.setIdx,
		.wrMask(lineWrMask),
		.wrData(lineWrData),
		.rdWays(lineWays)
	);

	lruAges lruAges_i (.clk, .reset, .setIdx, .touch, .touchWay, .victimWay);

	tagMatch tagMatch_i (.reqTag, .ways(tagWays), .hit, .hitWay);

endmodule

//--- cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

	typedef logic [`CACHE_WORD_BITS-1:0] word_t;

	typedef word_t [`CACHE_LINE_WORDS-1:0] line_t; // word 0 in the low bits

	typedef logic [`CACHE_ADDR_BITS-`CACHE_TAG_LSB-1:0] tag_t;

	typedef logic [$clog2(`CACHE_SETS)-1:0] setIdx_t;

	typedef logic [$clog2(`CACHE_LINE_WORDS)-1:0] wordSel_t;

	typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

	typedef logic [`CACHE_WAYS-1:0] wayMask_t;

	typedef logic [$clog2(`CACHE_AGE_MAX+1)-1:0] age_t;

	typedef struct packed
	{
		logic valid;
		tag_t tag;
	} tagEntry_t;

endpackage

//--- cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 8
`define CACHE_LINE_WORDS 4
`define CACHE_WORD_BITS 32
`define CACHE_ADDR_BITS 32

// top value of an lru age counter
`define CACHE_AGE_MAX 3

// byte address fields above the two ignored low bits
`define CACHE_WORD_LSB 2
`define CACHE_SET_LSB 4
`define CACHE_TAG_LSB 7

`endif

//--- cache_sva.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cacheSva import cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic sArready, sAwready,
	input logic sRvalid, sRready,
	input word_t sRdata,
	input logic [1:0] sRresp,
	input logic sBvalid, sBready,
	input logic [1:0] sBresp,
	input logic mArvalid, mArready,
	input logic [`CACHE_ADDR_BITS-1:0] mAraddr,
	input logic mAwvalid, mAwready,
	input logic [`CACHE_ADDR_BITS-1:0] mAwaddr,
	input logic mWvalid, mWready,
	input word_t mWdata,
	input logic [`CACHE_WORD_BITS/8-1:0] mWstrb
);
	int failCount = 0;

	function automatic void logFailure(input string what);
		failCount++;
		$error("%s", what);
	endfunction

	resetQuiet: assert property (@(posedge clk) $past(reset) |->
		!sArready && !sAwready && !sRvalid && !sBvalid && !mArvalid && !mAwvalid)
		else logFailure("a ready or valid output was high during reset");

	rHold: assert property (@(posedge clk) disable iff (reset)
		sRvalid && !sRready |=> sRvalid && $stable(sRdata))
		else logFailure("sRvalid dropped or sRdata changed before sRready");

	bHold: assert property (@(posedge clk) disable iff (reset)
		sBvalid && !sBready |=> sBvalid)
		else logFailure("sBvalid dropped before sBready");

	respOkay: assert property (@(posedge clk) disable iff (reset)
		(!sRvalid || sRresp == 2'b00) && (!sBvalid || sBresp == 2'b00))
		else logFailure("a slave response code was not OKAY");

	// no new request while a response waits
	busyClosed: assert property (@(posedge clk) disable iff (reset)
		sRvalid || sBvalid |-> !sArready && !sAwready)
		else logFailure("a new request was accepted while a response was pending");

	arHold: assert property (@(posedge clk) disable iff (reset)
		mArvalid && !mArready |=> mArvalid && $stable(mAraddr))
		else logFailure("memory read address changed or dropped before mArready");

	awHold: assert property (@(posedge clk) disable iff (reset)
		mAwvalid && !mAwready |=> mAwvalid && $stable(mAwaddr))
		else logFailure("memory write address changed or dropped before mAwready");

	wHold: assert property (@(posedge clk) disable iff (reset)
		mWvalid && !mWready |=> mWvalid && $stable(mWdata))
		else logFailure("memory write data changed or dropped before mWready");

	fullStrobe: assert property (@(posedge clk) disable iff (reset)
		mWvalid |-> mWstrb == '1)
		else logFailure("memory write strobes were partial");

endmodule

bind cacheTop cacheSva cacheSva_i (.*);

//--- files.f
+incdir+.
cache_pkg.sv
setStore.sv
lruAges.sv
tagMatch.sv
cacheController.sv
cacheTop.sv
cache_sva.sv
tb_cache.sv

//--- lruAges.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module lruAges import cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input setIdx_t setIdx,
	input logic touch,
	input way_t touchWay,
	output way_t victimWay
);
	age_t ages [`CACHE_SETS][`CACHE_WAYS];
	age_t touchedAge;

	assign touchedAge = ages[setIdx][touchWay]; // age before this access

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < `CACHE_SETS; s++)
			begin
				for (int w = 0; w < `CACHE_WAYS; w++)
					ages[s][w] <= '0;
			end
		end
		else if (touch)
		begin
			for (int w = 0; w < `CACHE_WAYS; w++)
			begin
				if (way_t'(w) == touchWay)
					ages[setIdx][w] <= age_t'(`CACHE_AGE_MAX); // most recent
				else if (ages[setIdx][w] > touchedAge)
					ages[setIdx][w] <= ages[setIdx][w] - 1'b1; // newer ways age down
			end
		end
	end

	// Ages in a set stay distinct once they are nonzero, so after the set
	// has filled exactly one way sits at zero and that way is the LRU one.
	always_comb
	begin
		victimWay = '0;
		for (int w = `CACHE_WAYS-1; w >= 0; w--)
		begin
			if (ages[setIdx][w] == '0)
				victimWay = way_t'(w); // lowest number wins
		end
	end

endmodule

//--- setStore.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module setStore import cache_pkg::*;
#(
	parameter type payload_t = line_t
)
(
	input logic clk,
	input logic reset,
	input setIdx_t setIdx,
	input wayMask_t wrMask,
	input payload_t wrData,
	output payload_t rdWays [`CACHE_WAYS]
);
	payload_t store [`CACHE_SETS][`CACHE_WAYS];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// all zero also means every tag entry is invalid
			for (int s = 0; s < `CACHE_SETS; s++)
			begin
				for (int w = 0; w < `CACHE_WAYS; w++)
					store[s][w] <= '0;
			end
		end
		else
		begin
			for (int w = 0; w < `CACHE_WAYS; w++)
			begin
				if (wrMask[w])
					store[setIdx][w] <= wrData;
			end
		end
	end

	// whole set visible at once
	always_comb
	begin
		for (int w = 0; w < `CACHE_WAYS; w++)
			rdWays[w] = store[setIdx][w];
	end

endmodule

//--- tagMatch.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module tagMatch import cache_pkg::*;
(
	input tag_t reqTag,
	input tagEntry_t ways [`CACHE_WAYS],
	output logic hit,
	output way_t hitWay
);
	wayMask_t match;

	always_comb
	begin
		hitWay = '0;
		for (int w = `CACHE_WAYS-1; w >= 0; w--)
		begin
			match[w] = ways[w].valid && (ways[w].tag == reqTag);
			if (match[w])
				hitWay = way_t'(w); // at most one way matches
		end
	end

	assign hit = |match;

endmodule

//--- tb_cache.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module tb_cache import cache_pkg::*;
();
	localparam int randomTxns = 200;
	localparam int directedTxns = 11;
	localparam int missCycles = 24; // accept, lookup, four 3-cycle beats, worst stall
	localparam int cycleLimit = (randomTxns + directedTxns) * missCycles + 20;

	logic clk = 1'b0;
	logic reset;
	logic [`CACHE_ADDR_BITS-1:0] sAwaddr, sAraddr, mAwaddr, mAraddr;
	logic sAwvalid, sAwready, sWvalid, sWready, sBvalid, sBready;
	logic sArvalid, sArready, sRvalid, sRready;
	word_t sWdata, sRdata, mWdata;
	logic [`CACHE_WORD_BITS/8-1:0] sWstrb, mWstrb;
	logic [1:0] sBresp, sRresp;
	logic mAwvalid, mWvalid, mBready, mArvalid, mRready;
	logic mAwready = 1'b0;
	logic mWready = 1'b0;
	logic mBvalid = 1'b0;
	logic mArready = 1'b0;
	logic mRvalid = 1'b0;
	word_t mRdata = '0;

	word_t mem [logic [31:0]];
	tag_t modelTags [`CACHE_SETS][`CACHE_WAYS];
	logic modelValid [`CACHE_SETS][`CACHE_WAYS];
	age_t modelAges [`CACHE_SETS][`CACHE_WAYS];
	logic [31:0] lcgState;
	logic [31:0] curAddr;
	logic [31:0] wrAddr;
	word_t wrData;
	int readMark;
	int mReadTotal = 0;
	int mWriteTotal = 0;
	int memErrors = 0;
	int tbErrors = 0;
	int readCount = 0;
	int writeCount = 0;
	int cycleCount = 0;

	cacheTop cacheTop_i (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// unwritten words read back as their own address scrambled
	function automatic word_t memValue(input logic [31:0] addr);
		return mem.exists(addr) ? mem[addr] : (addr ^ 32'h5a5a0000);
	endfunction

	function automatic logic [31:0] lruAddr(input int idx, input logic [1:0] word);
		return {tag_t'(25'h0abc0 + idx), 3'd2, word, 2'b00};
	endfunction

	function automatic void modelLookup(input logic [31:0] addr, output logic isHit,
		output way_t way);
		setIdx_t s;
		s = addr[`CACHE_TAG_LSB-1:`CACHE_SET_LSB];
		isHit = 1'b0;
		way = '0;
		for (int w = `CACHE_WAYS-1; w >= 0; w--)
		begin
			if (modelAges[s][w] == '0)
				way = way_t'(w); // lowest way at age zero is the victim
		end
		for (int w = 0; w < `CACHE_WAYS; w++)
		begin
			if (modelValid[s][w] && modelTags[s][w] == addr[31:`CACHE_TAG_LSB])
			begin
				isHit = 1'b1;
				way = way_t'(w);
			end
		end
	endfunction

	function automatic void modelTouch(input setIdx_t s, input way_t w);
		age_t oldAge;
		oldAge = modelAges[s][w];
		for (int v = 0; v < `CACHE_WAYS; v++)
		begin
			if (way_t'(v) == w)
				modelAges[s][v] = age_t'(`CACHE_AGE_MAX);
			else if (modelAges[s][v] > oldAge)
				modelAges[s][v]--;
		end
	endfunction

	// memory side answers one cycle after valid
	always @(posedge clk)
	begin : memModel
		logic arFire;
		logic wrFire;
		logic [31:0] expAddr;
		logic arReadyNext;
		logic awReadyNext;
		logic wReadyNext;
		logic rValidNext;
		logic bValidNext;
		word_t rDataNext;
		arFire = !reset && mArvalid && mArready;
		wrFire = !reset && mAwvalid && mAwready && mWvalid && mWready;
		arReadyNext = !reset && mArvalid && !mArready;
		awReadyNext = !reset && mAwvalid && !mAwready;
		wReadyNext = !reset && mWvalid && !mWready;
		rValidNext = !reset && (arFire || (mRvalid && !mRready));
		bValidNext = !reset && (wrFire || (mBvalid && !mBready));
		rDataNext = mRdata;
		if (arFire)
		begin
			expAddr = {curAddr[31:4], 4'h0} + 32'((mReadTotal - readMark) * 4);
			assert (mAraddr == expAddr)
			else
			begin
				memErrors++;
				$display("ERR mAraddr: got %h, expected %h", mAraddr, expAddr);
			end
			mReadTotal++;
			rDataNext = memValue(mAraddr);
		end
		if (wrFire)
		begin
			assert (mAwaddr == wrAddr && mWdata == wrData)
			else
			begin
				memErrors++;
				$display("ERR mAwaddr/mWdata: got %h/%h, expected %h/%h", mAwaddr, mWdata,
					wrAddr, wrData);
			end
			mWriteTotal++;
			mem[mAwaddr] = mWdata;
		end
		#2;
		mArready = arReadyNext;
		mAwready = awReadyNext;
		mWready = wReadyNext;
		mRvalid = rValidNext;
		mRdata = rDataNext;
		mBvalid = bValidNext;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout after %0d cycles, a transaction never completed", cycleCount);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic readCheck(input logic [31:0] addr, output logic sawHit);
		logic predHit;
		way_t way;
		word_t expData;
		int cycles;
		int stall;
		int reads;
		setIdx_t s;
		modelLookup(addr, predHit, way);
		s = addr[`CACHE_TAG_LSB-1:`CACHE_SET_LSB];
		curAddr = addr;
		readMark = mReadTotal;
		stall = int'(nextRand() % 4);
		sAraddr = addr;
		sArvalid = 1'b1;
		do
		begin
			@(posedge clk);
		end
		while (!sArready);
		#2;
		sArvalid = 1'b0;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
		end
		while (!sRvalid);
		reads = mReadTotal - readMark;
		expData = memValue(addr);
		assert (sRdata == expData)
		else
		begin
			tbErrors++;
			$display("ERR sRdata: got %h, expected %h at address %h", sRdata, expData, addr);
		end
		if (predHit)
		begin
			assert (cycles == 2 && reads == 0)
			else
			begin
				tbErrors++;
				$display("read of %h should hit but took %0d cycles and %0d memory reads",
					addr, cycles, reads);
			end
		end
		else
		begin
			assert (reads == 4)
			else
			begin
				tbErrors++;
				$display("read of %h should miss but issued %0d memory reads", addr, reads);
			end
		end
		repeat (stall)
			@(posedge clk); // hold sRready low a while
		#2;
		sRready = 1'b1;
		@(posedge clk);
		#2;
		sRready = 1'b0;
		sawHit = (reads == 0);
		if (!predHit)
		begin
			modelTags[s][way] = addr[31:`CACHE_TAG_LSB];
			modelValid[s][way] = 1'b1;
		end
		modelTouch(s, way);
		readCount++;
	endtask

	task automatic writeCheck(input logic [31:0] addr, input word_t data);
		logic predHit;
		way_t way;
		int stall;
		int writeMark;
		modelLookup(addr, predHit, way);
		wrAddr = addr;
		wrData = data;
		writeMark = mWriteTotal;
		stall = int'(nextRand() % 4);
		sAwaddr = addr;
		sWdata = data;
		sAwvalid = 1'b1;
		sWvalid = 1'b1;
		do
		begin
			@(posedge clk);
		end
		while (!(sAwready && sWready));
		#2;
		sAwvalid = 1'b0;
		sWvalid = 1'b0;
		do
		begin
			@(posedge clk);
		end
		while (!sBvalid);
		assert (mWriteTotal - writeMark == 1)
		else
		begin
			tbErrors++;
			$display("write to %h issued %0d memory writes instead of one", addr,
				mWriteTotal - writeMark);
		end
		repeat (stall)
			@(posedge clk);
		#2;
		sBready = 1'b1;
		@(posedge clk);
		#2;
		sBready = 1'b0;
		if (predHit)
			modelTouch(addr[`CACHE_TAG_LSB-1:`CACHE_SET_LSB], way); // misses do not allocate
		writeCount++;
	endtask

	initial
	begin
		logic sawHit;
		logic [31:0] r;
		logic [31:0] addr;
		int assertErrors;
		reset = 1'b1;
		sAwaddr = '0;
		sAwvalid = 1'b0;
		sWdata = '0;
		sWstrb = 4'hf;
		sWvalid = 1'b0;
		sBready = 1'b0;
		sAraddr = '0;
		sArvalid = 1'b0;
		sRready = 1'b0;
		lcgState = 32'hebbf5277;
		for (int s = 0; s < `CACHE_SETS; s++)
		begin
			for (int w = 0; w < `CACHE_WAYS; w++)
			begin
				modelTags[s][w] = '0;
				modelValid[s][w] = 1'b0;
				modelAges[s][w] = '0;
			end
		end
		repeat (3)
			@(posedge clk);
		#2;
		reset = 1'b0;

		// five tags in set 2, then the oldest one comes back
		for (int i = 0; i < 5; i++)
		begin
			readCheck(lruAddr(i, 2'(i)), sawHit);
			assert (!sawHit)
			else
			begin
				tbErrors++;
				$display("first read of tag %0d in set 2 hit an empty line", i);
			end
		end
		readCheck(lruAddr(0, 2'd3), sawHit);
		assert (!sawHit)
		else
		begin
			tbErrors++;
			$display("least recently used tag in set 2 was not evicted");
		end
		for (int i = 2; i < 5; i++)
		begin
			readCheck(lruAddr(i, 2'd0), sawHit);
			assert (sawHit)
			else
			begin
				tbErrors++;
				$display("tag %0d in set 2 was evicted out of LRU order", i);
			end
		end
		writeCheck(lruAddr(4, 2'd1), nextRand());
		readCheck(lruAddr(4, 2'd1), sawHit);
		assert (sawHit)
		else
		begin
			tbErrors++;
			$display("read after a write hit in set 2 missed");
		end

		// six tags over sets 4 and 5 force evictions and write hits
		for (int i = 0; i < randomTxns; i++)
		begin
			r = nextRand();
			addr = {tag_t'(25'h1a0 + r[31:24] % 8'd6), 2'b10, r[20], r[18:17], 2'b00};
			if (r[15:12] < 4'd5)
				writeCheck(addr, nextRand());
			else
				readCheck(addr, sawHit);
		end
		repeat (2)
			@(posedge clk);

		assertErrors = cacheTop_i.cacheSva_i.failCount;
		$display("reads %0d, writes %0d, testbench errors %0d, assertion errors %0d",
			readCount, writeCount, tbErrors + memErrors, assertErrors);
		if (tbErrors + memErrors + assertErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
